/* common/rename_defs.svh */
//////////////////////////////////////////////////
// Size macros for the register-rename stage
//////////////////////////////////////////////////

`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Register file sizes
`define RN_NUM_ARCH_REGS 32     // RISC-V integer registers x0..x31
`define RN_NUM_PHYS_REGS 64     // Physical registers behind the map

// Checkpoint slots, one always kept free so head never catches tail
`define RN_NUM_CHECKPOINTS 4

// Registers not mapped at any time sit in the free list
`define RN_FREE_DEPTH (`RN_NUM_PHYS_REGS - `RN_NUM_ARCH_REGS)

// Live checkpoints at which a new one must wait
`define RN_MAX_LIVE_CKPTS (`RN_NUM_CHECKPOINTS - 1)

`endif

/* common/rename_pkg.sv */
//////////////////////////////////////////////////
// Register, checkpoint and rename struct types
//////////////////////////////////////////////////

`include "rename_defs.svh"

package rename_pkg;

    // Register indices
    typedef logic [$clog2(`RN_NUM_ARCH_REGS)-1:0] arch_reg_t;   // x0..x31
    typedef logic [$clog2(`RN_NUM_PHYS_REGS)-1:0] phys_reg_t;   // p0..p63

    // Checkpoint label, wraps modulo the slot count
    typedef logic [$clog2(`RN_NUM_CHECKPOINTS)-1:0] ckpt_ptr_t;

    // Request from decode
    typedef struct packed {
        arch_reg_t src1;        // First source operand
        arch_reg_t src2;        // Second source operand
        arch_reg_t dst;         // Destination, x0 allowed
        logic      dst_valid;   // Instruction writes a register
        logic      checkpoint;  // Branch, snapshot after this one
    } rename_req_t;

    // Renamed instruction, one cycle after acceptance
    typedef struct packed {
        phys_reg_t src1;        // Mapping of src1
        phys_reg_t src2;        // Mapping of src2
        phys_reg_t old_dst;     // Previous mapping of dst, freed at retire
        phys_reg_t new_dst;     // Fresh register, or old_dst when none
        ckpt_ptr_t ckpt;        // Label of the snapshot taken
        logic      ckpt_valid;  // A snapshot was taken
    } rename_rsp_t;

    // Misprediction recovery
    typedef struct packed {
        logic      valid;       // Single-cycle strobe
        ckpt_ptr_t ckpt;        // Snapshot to roll back to
    } recover_t;

endpackage

/* rename/rename_table.sv */
//////////////////////////////////////////////////
// Live rename map, checkpoint banks, ckpt labels
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rename_defs.svh"

module rename_table (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  logic                  rename_en_i,    // Request accepted this cycle
    input  rename_pkg::arch_reg_t src1_i,
    input  rename_pkg::arch_reg_t src2_i,
    input  rename_pkg::arch_reg_t dst_i,
    input  logic                  write_en_i,     // Allocation made for a dst other than x0
    input  rename_pkg::phys_reg_t new_dst_i,

    input  logic                  ckpt_en_i,      // Snapshot after this rename
    input  rename_pkg::recover_t  recover_i,
    input  logic                  delete_ckpt_i,  // Oldest branch resolved

    output rename_pkg::phys_reg_t src1_o,
    output rename_pkg::phys_reg_t src2_o,
    output rename_pkg::phys_reg_t old_dst_o,

    output rename_pkg::ckpt_ptr_t ckpt_alloc_o,   // Label handed out this cycle
    output logic                  ckpts_full_o
);

    import rename_pkg::*;

    localparam int CNT_W = $clog2(`RN_NUM_CHECKPOINTS) + 1;  // Holds 0..NUM_CHECKPOINTS

    // Architectural state
    phys_reg_t map_q   [`RN_NUM_ARCH_REGS];
    phys_reg_t map_nxt [`RN_NUM_ARCH_REGS];

    // One full copy of the map per checkpoint label
    phys_reg_t bank_q [`RN_NUM_CHECKPOINTS][`RN_NUM_ARCH_REGS];

    // Labels tail..head-1 are live
    ckpt_ptr_t        head_q;       // Next label to hand out
    ckpt_ptr_t        tail_q;       // Oldest live label
    logic [CNT_W-1:0] count_q;      // Live checkpoints

    logic      wr_fire;
    logic      ckpt_fire;
    ckpt_ptr_t tail_nxt;

    assign wr_fire   = rename_en_i & write_en_i;
    assign ckpt_fire = rename_en_i & ckpt_en_i;
    assign tail_nxt  = tail_q + ckpt_ptr_t'(delete_ckpt_i);

    // Lookups see the map before this instruction's own write
    assign src1_o    = map_q[src1_i];
    assign src2_o    = map_q[src2_i];
    assign old_dst_o = map_q[dst_i];

    assign ckpt_alloc_o = head_q;
    assign ckpts_full_o = (count_q == CNT_W'(`RN_MAX_LIVE_CKPTS));

    // Map after this rename and source of the snapshot
    always_comb begin
        map_nxt = map_q;
        if (wr_fire) begin
            map_nxt[dst_i] = new_dst_i;
        end
    end

    // Live map
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `RN_NUM_ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);     // Identity map of xN onto pN
            end
        end else if (recover_i.valid) begin
            map_q <= bank_q[recover_i.ckpt];    // Roll back and drop younger renames
        end else begin
            map_q <= map_nxt;
        end
    end

    // Snapshot banks
    // Bank captures the map including the branch's own destination
    always_ff @(posedge clk_i) begin
        if (ckpt_fire && !recover_i.valid) begin
            bank_q[head_q] <= map_nxt;
        end
    end

    // Checkpoint labels and live count
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            tail_q <= tail_nxt;                 // Release of the oldest
            if (recover_i.valid) begin
                // Recovered label and all younger ones are freed
                head_q  <= recover_i.ckpt;
                count_q <= CNT_W'(ckpt_ptr_t'(recover_i.ckpt - tail_nxt));
            end else begin
                if (ckpt_fire) begin
                    head_q <= head_q + 1'b1;
                end
                count_q <= count_q + CNT_W'(ckpt_fire) - CNT_W'(delete_ckpt_i);
            end
        end
    end

    // Top must hold a checkpoint back while all usable slots are live
    a_no_ckpt_when_full: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        ckpt_fire |-> !ckpts_full_o
    ) else $error("Checkpoint taken with %0d live checkpoints", count_q);

    // Write enable must already exclude x0 so that it stays on p0
    a_no_x0_write: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        wr_fire |-> (dst_i != '0)
    ) else $error("Rename write to x0");

endmodule

/* rename/free_list.sv */
//////////////////////////////////////////////////
// Free physical register queue, saved heads
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rename_defs.svh"

module free_list (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  logic                  alloc_en_i,     // Pop the head register
    output rename_pkg::phys_reg_t alloc_reg_o,    // Head register, valid when not empty
    output logic                  empty_o,

    input  logic                  commit_i,       // Retired old_dst comes back
    input  rename_pkg::phys_reg_t commit_reg_i,

    input  logic                  ckpt_en_i,      // Save head under the new label
    input  rename_pkg::ckpt_ptr_t ckpt_alloc_i,
    input  rename_pkg::recover_t  recover_i
);

    import rename_pkg::*;

    localparam int IDX_W = $clog2(`RN_FREE_DEPTH);

    // Pointers carry a wrap bit, so full and empty stay apart on restore
    typedef logic [IDX_W:0] fptr_t;

    phys_reg_t fifo_q [`RN_FREE_DEPTH];
    fptr_t     head_q;                              // Next register to hand out
    fptr_t     tail_q;                              // Next slot for a returned register
    fptr_t     count_q;                             // Free registers, 0..DEPTH

    fptr_t     saved_head_q [`RN_NUM_CHECKPOINTS];  // Head after the branch's pop

    fptr_t head_nxt;
    fptr_t tail_nxt;

    assign head_nxt = head_q + fptr_t'(alloc_en_i);
    assign tail_nxt = tail_q + fptr_t'(commit_i);

    assign alloc_reg_o = fifo_q[head_q[IDX_W-1:0]];
    assign empty_o     = (count_q == '0);

    // Queue storage and pointers
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            // p32..p63 free in order, x0..x31 own p0..p31
            for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
                fifo_q[i] <= phys_reg_t'(`RN_NUM_ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= fptr_t'(`RN_FREE_DEPTH);     // Wrap bit set, list full
            count_q <= fptr_t'(`RN_FREE_DEPTH);
        end else begin
            if (commit_i) begin
                fifo_q[tail_q[IDX_W-1:0]] <= commit_reg_i;
            end
            tail_q <= tail_nxt;                     // Retire keeps going during recovery

            if (recover_i.valid) begin
                // Pops after the checkpoint are undone, pushes are kept
                head_q  <= saved_head_q[recover_i.ckpt];
                count_q <= tail_nxt - saved_head_q[recover_i.ckpt];
            end else begin
                head_q  <= head_nxt;
                count_q <= count_q + fptr_t'(commit_i) - fptr_t'(alloc_en_i);
            end
        end
    end

    // Saved head per checkpoint label, includes this cycle's pop
    always_ff @(posedge clk_i) begin
        if (ckpt_en_i && !recover_i.valid) begin
            saved_head_q[ckpt_alloc_i] <= head_nxt;
        end
    end

    // Top stalls on empty, so an allocation here means a broken stall path
    a_no_pop_empty: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        alloc_en_i |-> !empty_o
    ) else $error("Free list popped while empty");

    // Retirement can only return a register that was handed out
    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        commit_i |-> (count_q != fptr_t'(`RN_FREE_DEPTH))
    ) else $error("Free list pushed while full, reg %0d", commit_reg_i);

endmodule

/* rename/rename_unit.sv */
//////////////////////////////////////////////////
// Rename stage top, accept/stall and result reg
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rename_unit (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    input  logic                    valid_i,        // Decode has an instruction
    input  rename_pkg::rename_req_t req_i,

    input  rename_pkg::recover_t    recover_i,      // Branch mispredicted
    input  logic                    delete_ckpt_i,  // Oldest branch resolved correctly

    input  logic                    commit_i,       // Retire frees a register
    input  rename_pkg::phys_reg_t   commit_reg_i,

    output logic                    stall_o,        // Decode must hold its request
    output logic                    rsp_valid_o,
    output rename_pkg::rename_rsp_t rsp_o
);

    import rename_pkg::*;

    logic        accept;
    logic        alloc_en;
    logic        ckpt_en;
    logic        fl_empty;
    logic        ckpts_full;

    phys_reg_t   src1_map;
    phys_reg_t   src2_map;
    phys_reg_t   old_dst_map;
    phys_reg_t   alloc_reg;
    ckpt_ptr_t   ckpt_label;

    rename_rsp_t rsp_d;
    rename_rsp_t rsp_q;
    logic        rsp_valid_q;

    // Stall covers empty list, checkpoint overflow and the recovery cycle
    assign stall_o  = fl_empty | (valid_i & req_i.checkpoint & ckpts_full) | recover_i.valid;
    assign accept   = valid_i & ~stall_o;
    assign alloc_en = accept & req_i.dst_valid & (req_i.dst != '0);    // x0 allocates nothing
    assign ckpt_en  = accept & req_i.checkpoint;

    rename_table rename_table_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .rename_en_i   (accept),
        .src1_i        (req_i.src1),
        .src2_i        (req_i.src2),
        .dst_i         (req_i.dst),
        .write_en_i    (alloc_en),
        .new_dst_i     (alloc_reg),
        .ckpt_en_i     (ckpt_en),
        .recover_i     (recover_i),
        .delete_ckpt_i (delete_ckpt_i),
        .src1_o        (src1_map),
        .src2_o        (src2_map),
        .old_dst_o     (old_dst_map),
        .ckpt_alloc_o  (ckpt_label),
        .ckpts_full_o  (ckpts_full)
    );

    free_list free_list_i (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .alloc_en_i   (alloc_en),
        .alloc_reg_o  (alloc_reg),
        .empty_o      (fl_empty),
        .commit_i     (commit_i),
        .commit_reg_i (commit_reg_i),
        .ckpt_en_i    (ckpt_en),
        .ckpt_alloc_i (ckpt_label),   // Same label the table assigns
        .recover_i    (recover_i)
    );

    // Result of this cycle's rename
    always_comb begin
        rsp_d.src1       = src1_map;
        rsp_d.src2       = src2_map;
        rsp_d.old_dst    = old_dst_map;
        rsp_d.new_dst    = alloc_en ? alloc_reg : old_dst_map;  // No dst, repeat old mapping
        rsp_d.ckpt       = ckpt_label;
        rsp_d.ckpt_valid = ckpt_en;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

    // Resolve only for a branch that holds a checkpoint
    a_delete_has_ckpt: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        delete_ckpt_i |-> (rename_table_i.count_q != '0)
    ) else $error("delete_ckpt_i with no live checkpoint");

endmodule

/* verif/rename_unit_tb.sv */
//////////////////////////////////////////////////
// Rename stage testbench, step table, ref model
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rename_defs.svh"

module rename_unit_tb;

    import rename_pkg::*;

    localparam int NUM_CKPTS = `RN_NUM_CHECKPOINTS;

    // Step operations
    localparam logic [2:0] OP_IDLE    = 3'd0;
    localparam logic [2:0] OP_REN     = 3'd1;
    localparam logic [2:0] OP_REN_CK  = 3'd2;   // Rename and take a checkpoint
    localparam logic [2:0] OP_RECOVER = 3'd3;
    localparam logic [2:0] OP_DELETE  = 3'd4;
    localparam logic [2:0] OP_COMMIT  = 3'd5;

    typedef struct packed {
        logic [2:0] op;
        logic       rnd;        // Random src1, src2 and dst from the LCG
        arch_reg_t  src1;
        arch_reg_t  src2;
        arch_reg_t  dst;
        logic       dst_valid;
        logic [5:0] arg;        // Recover label or committed register
        logic [5:0] reps;       // Cycles the step is repeated
        logic       exp_stall;
    } step_t;

    localparam int NUM_STEPS = 29;

    // op, rnd, src1, src2, dst, dst_valid, arg, reps, exp_stall
    localparam step_t STEPS [NUM_STEPS] = '{
        '{OP_REN,     1'b0, 5'd3,  5'd7,  5'd0,  1'b0, 6'd0, 6'd1,  1'b0}, // Identity reads
        '{OP_REN,     1'b0, 5'd1,  5'd2,  5'd5,  1'b1, 6'd0, 6'd1,  1'b0}, // x5 gets p32
        '{OP_REN,     1'b0, 5'd5,  5'd6,  5'd6,  1'b1, 6'd0, 6'd1,  1'b0}, // p33 and a read of p32
        '{OP_REN,     1'b0, 5'd0,  5'd0,  5'd7,  1'b1, 6'd0, 6'd1,  1'b0}, // p34
        '{OP_REN,     1'b0, 5'd5,  5'd7,  5'd5,  1'b1, 6'd0, 6'd1,  1'b0}, // Old dst p32
        '{OP_REN,     1'b0, 5'd5,  5'd6,  5'd0,  1'b1, 6'd0, 6'd1,  1'b0}, // x0 dst pops nothing
        '{OP_REN,     1'b0, 5'd5,  5'd0,  5'd0,  1'b0, 6'd0, 6'd1,  1'b0},
        '{OP_REN_CK,  1'b0, 5'd1,  5'd2,  5'd9,  1'b1, 6'd0, 6'd1,  1'b0}, // Branch with label 0
        '{OP_REN,     1'b1, 5'd0,  5'd0,  5'd0,  1'b1, 6'd0, 6'd3,  1'b0}, // Wrong path
        '{OP_RECOVER, 1'b0, 5'd0,  5'd0,  5'd0,  1'b0, 6'd0, 6'd1,  1'b1},
        '{OP_REN,     1'b0, 5'd9,  5'd5,  5'd10, 1'b1, 6'd0, 6'd1,  1'b0}, // p37 handed out again
        '{OP_REN_CK,  1'b0, 5'd0,  5'd0,  5'd11, 1'b1, 6'd0, 6'd1,  1'b0},
        '{OP_REN_CK,  1'b0, 5'd11, 5'd0,  5'd12, 1'b1, 6'd0, 6'd1,  1'b0},
        '{OP_REN_CK,  1'b0, 5'd12, 5'd0,  5'd13, 1'b1, 6'd0, 6'd1,  1'b0}, // Three live
        '{OP_REN_CK,  1'b0, 5'd13, 5'd0,  5'd14, 1'b1, 6'd0, 6'd2,  1'b1}, // Held back
        '{OP_DELETE,  1'b0, 5'd0,  5'd0,  5'd0,  1'b0, 6'd0, 6'd1,  1'b0},
        '{OP_REN_CK,  1'b0, 5'd13, 5'd0,  5'd14, 1'b1, 6'd0, 6'd1,  1'b0}, // Label 3
        '{OP_DELETE,  1'b0, 5'd0,  5'd0,  5'd0,  1'b0, 6'd0, 6'd1,  1'b0},
        '{OP_REN_CK,  1'b0, 5'd14, 5'd0,  5'd15, 1'b1, 6'd0, 6'd1,  1'b0}, // Wraps to 0
        '{OP_RECOVER, 1'b0, 5'd0,  5'd0,  5'd0,  1'b0, 6'd3, 6'd1,  1'b1},
        '{OP_REN,     1'b0, 5'd14, 5'd15, 5'd0,  1'b0, 6'd0, 6'd1,  1'b0},
        '{OP_DELETE,  1'b0, 5'd0,  5'd0,  5'd0,  1'b0, 6'd0, 6'd1,  1'b0},
        '{OP_REN,     1'b1, 5'd0,  5'd0,  5'd0,  1'b1, 6'd0, 6'd6,  1'b0},
        '{OP_REN,     1'b1, 5'd0,  5'd0,  5'd0,  1'b1, 6'd0, 6'd16, 1'b0}, // Drains the list
        '{OP_REN,     1'b0, 5'd1,  5'd2,  5'd3,  1'b1, 6'd0, 6'd2,  1'b1}, // Empty
        '{OP_COMMIT,  1'b0, 5'd0,  5'd0,  5'd0,  1'b0, 6'd5, 6'd1,  1'b1}, // p5 returns
        '{OP_REN,     1'b0, 5'd3,  5'd5,  5'd20, 1'b1, 6'd0, 6'd1,  1'b0}, // Gets p5
        '{OP_REN,     1'b0, 5'd0,  5'd0,  5'd21, 1'b1, 6'd0, 6'd1,  1'b1},
        '{OP_IDLE,    1'b0, 5'd0,  5'd0,  5'd0,  1'b0, 6'd0, 6'd2,  1'b1}
    };

    logic        clk_i;
    logic        rstn_i;
    logic        valid_i;
    rename_req_t req_i;
    recover_t    recover_i;
    logic        delete_ckpt_i;
    logic        commit_i;
    phys_reg_t   commit_reg_i;
    logic        stall_o;
    logic        rsp_valid_o;
    rename_rsp_t rsp_o;

    // Reference model state
    phys_reg_t   ref_map   [`RN_NUM_ARCH_REGS];
    phys_reg_t   ref_bank  [NUM_CKPTS][`RN_NUM_ARCH_REGS];
    phys_reg_t   ref_free  [$];                 // Allocation order
    phys_reg_t   ref_saved [NUM_CKPTS][$];      // Free order per label
    int          ref_head;
    int          ref_tail;
    rename_rsp_t exp_rsp;
    logic        exp_pending;                   // Response due at the next cycle

    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit;
    logic [31:0] lcg_state;

    rename_unit rename_unit_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .valid_i       (valid_i),
        .req_i         (req_i),
        .recover_i     (recover_i),
        .delete_ckpt_i (delete_ckpt_i),
        .commit_i      (commit_i),
        .commit_reg_i  (commit_reg_i),
        .stall_o       (stall_o),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_o         (rsp_o)
    );

    always #2 clk_i = ~clk_i;                   // 4 ns period

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int total_cycles();
        int n;
        n = 8 + 2;                              // Reset and final flush
        for (int i = 0; i < NUM_STEPS; i++) begin
            n += int'(STEPS[i].reps);
        end
        return n;
    endfunction

    task automatic check_val(input string name, input logic [7:0] exp_v,
                             input logic [7:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            errors++;
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp_v, act_v);
        end
    endtask

    task automatic reset_model();
        ref_free.delete();
        for (int i = 0; i < `RN_NUM_ARCH_REGS; i++) begin
            ref_map[i] = phys_reg_t'(i);
        end
        for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
            ref_free.push_back(phys_reg_t'(`RN_NUM_ARCH_REGS + i));
        end
        ref_head = 0;
        ref_tail = 0;
    endtask

    // Compare last cycle's prediction with the registered result
    task automatic check_response();
        check_val("rsp_valid_o", 8'(exp_pending), 8'(rsp_valid_o));
        if (exp_pending && rsp_valid_o) begin
            check_val("rsp_o.src1", 8'(exp_rsp.src1), 8'(rsp_o.src1));
            check_val("rsp_o.src2", 8'(exp_rsp.src2), 8'(rsp_o.src2));
            check_val("rsp_o.old_dst", 8'(exp_rsp.old_dst), 8'(rsp_o.old_dst));
            check_val("rsp_o.new_dst", 8'(exp_rsp.new_dst), 8'(rsp_o.new_dst));
            check_val("rsp_o.ckpt", 8'(exp_rsp.ckpt), 8'(rsp_o.ckpt));
            check_val("rsp_o.ckpt_valid", 8'(exp_rsp.ckpt_valid), 8'(rsp_o.ckpt_valid));
        end
    endtask

    task automatic predict_rename(input rename_req_t req);
        logic alloc;
        alloc              = req.dst_valid && (req.dst != 5'd0);    // x0 is never renamed
        exp_rsp.src1       = ref_map[req.src1];
        exp_rsp.src2       = ref_map[req.src2];
        exp_rsp.old_dst    = ref_map[req.dst];
        exp_rsp.new_dst    = ref_map[req.dst];
        exp_rsp.ckpt       = ckpt_ptr_t'(ref_head);
        exp_rsp.ckpt_valid = req.checkpoint;
        if (alloc && ref_free.size() == 0) begin
            errors++;
            $display("Model has no free register for an accepted rename at %0t", $time);
        end else if (alloc) begin
            exp_rsp.new_dst  = ref_free.pop_front();
            ref_map[req.dst] = exp_rsp.new_dst;
        end
        if (req.checkpoint) begin
            ref_bank[ref_head]  = ref_map;      // Snapshot after own write and pop
            ref_saved[ref_head] = ref_free;
            ref_head            = (ref_head + 1) % NUM_CKPTS;
        end
    endtask

    task automatic apply_control(input step_t s);
        int label;
        label = int'(s.arg[1:0]);
        case (s.op)
            OP_RECOVER: begin
                ref_map  = ref_bank[label];
                ref_free = ref_saved[label];
                ref_head = label;
            end
            OP_DELETE: begin
                ref_tail = (ref_tail + 1) % NUM_CKPTS;
            end
            OP_COMMIT: begin
                ref_free.push_back(phys_reg_t'(s.arg));
                for (int k = 0; k < NUM_CKPTS; k++) begin
                    ref_saved[k].push_back(phys_reg_t'(s.arg));   // Survives a rollback
                end
            end
            default: ;
        endcase
    endtask

    // One clock of a step with inputs changed on the falling edge
    task automatic run_cycle(input step_t s);
        rename_req_t req;
        logic [31:0] r;
        logic        req_valid;
        @(negedge clk_i);
        check_response();
        req            = '0;
        req.src1       = s.src1;
        req.src2       = s.src2;
        req.dst        = s.dst;
        req.dst_valid  = s.dst_valid;
        req.checkpoint = (s.op == OP_REN_CK);
        if (s.rnd) begin
            r        = next_rand();
            req.src1 = r[20:16];
            req.src2 = r[25:21];
            req.dst  = arch_reg_t'(1 + r[31:26] % 31);     // Never x0
        end
        req_valid       = (s.op == OP_REN) || (s.op == OP_REN_CK) || (s.op == OP_RECOVER);
        valid_i         = req_valid;
        req_i           = req;
        recover_i.valid = (s.op == OP_RECOVER);
        recover_i.ckpt  = s.arg[1:0];
        delete_ckpt_i   = (s.op == OP_DELETE);
        commit_i        = (s.op == OP_COMMIT);
        commit_reg_i    = phys_reg_t'(s.arg);
        #1;
        check_val("stall_o", 8'(s.exp_stall), 8'(stall_o));
        exp_pending = req_valid && !s.exp_stall;
        if (exp_pending) begin
            predict_rename(req);
        end
        apply_control(s);
    endtask

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout, run still busy after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        clk_i         = 1'b0;
        rstn_i        = 1'b0;
        valid_i       = 1'b0;
        req_i         = '0;
        recover_i     = '0;
        delete_ckpt_i = 1'b0;
        commit_i      = 1'b0;
        commit_reg_i  = '0;
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        exp_pending   = 1'b0;
        exp_rsp       = '0;
        lcg_state     = 32'h68f1b9fb;
        cycle_limit   = total_cycles() * 4 + 100;
        reset_model();

        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        #1;
        check_val("stall_o", 8'd0, 8'(stall_o));    // Idle after reset

        for (int i = 0; i < NUM_STEPS; i++) begin
            for (int k = 0; k < int'(STEPS[i].reps); k++) begin
                run_cycle(STEPS[i]);
            end
        end
        @(negedge clk_i);
        check_response();
        valid_i       = 1'b0;
        recover_i     = '0;
        delete_ckpt_i = 1'b0;
        commit_i      = 1'b0;

        $display("Errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+common
common/rename_pkg.sv
rename/rename_table.sv
rename/free_list.sv
rename/rename_unit.sv
verif/rename_unit_tb.sv

/* Makefile */
# Verilator flow for the rename stage

VERILATOR  ?= verilator
TB_TOP     ?= rename_unit_tb
RTL_TOP    ?= rename_unit
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= Test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
